// ==== include/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Core address and store data width
`define ADDR_BITS 32

// One data-array line
`define LINE_BITS 128

// Bytes per line, also the width of the byte-write mask
`define LINE_BYTES 16

// Address split
// Tag sits in bits 31..10
`define TAG_BITS 22
// Index sits in bits 9..4
`define INDEX_BITS 6
// Byte offset inside the line
`define OFFSET_BITS 4

// Access type field
`define TYPE_BITS 3

// Access type codes
`define CACHE_BYTE    3'b000
`define CACHE_HWORD   3'b001
`define CACHE_WORD    3'b010
// Unsigned forms only matter for loads
`define CACHE_BYTE_U  3'b100
`define CACHE_HWORD_U 3'b101

`endif

// ==== rtl/cache_pkg.sv ====
`include "cache_consts.svh"

package cache_pkg;

  // Access size as issued by the core
  typedef enum logic [`TYPE_BITS-1:0] {
    acc_byte    = `CACHE_BYTE,
    acc_hword   = `CACHE_HWORD,
    acc_word    = `CACHE_WORD,
    acc_byte_u  = `CACHE_BYTE_U,
    acc_hword_u = `CACHE_HWORD_U
  } access_t;

  // Store path FSM
  typedef enum logic [2:0] {
    st_idle,
    st_write_mem,
    st_read_array,
    st_check_hit,
    st_write_line
  } store_state_t;

  // Address fields
  typedef logic [`TAG_BITS-1:0]    tag_t;
  typedef logic [`INDEX_BITS-1:0]  index_t;
  typedef logic [`OFFSET_BITS-1:0] offset_t;

  // Core word
  typedef logic [`ADDR_BITS-1:0] word_t;

  // Data-array line and its byte-write mask
  typedef logic [`LINE_BITS-1:0]  line_t;
  // Active low, one bit per byte
  typedef logic [`LINE_BYTES-1:0] byte_mask_t;

endpackage

// ==== rtl/store_if.sv ====
`timescale 1ns/10ps

interface store_if;
  import cache_pkg::*;

  // Captured address fields
  index_t  index;
  tag_t    tag;
  offset_t offset;

  // Captured access type and store data
  access_t dtype;
  word_t   wdata;

  // High only in the line write cycle
  logic    merge_en;

  // Controller side
  modport ctrl (
    output index, tag, offset, dtype, wdata, merge_en
  );

  // Merger side needs the lane info and data only
  modport merge (
    input offset, dtype, wdata, merge_en
  );

endinterface

// ==== rtl/store_ctrl.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module store_ctrl (
  input  logic               clk,
  input  logic               rst,
  // Core side
  input  logic               core_req,
  input  logic               core_write,
  input  cache_pkg::word_t   core_addr,
  input  cache_pkg::word_t   core_in,
  input  cache_pkg::access_t core_type,
  output logic               core_wait,
  // Memory side
  output logic               d_req,
  output logic               d_write,
  output cache_pkg::word_t   d_addr,
  output cache_pkg::word_t   d_in,
  output cache_pkg::access_t d_type,
  input  logic               d_wait,
  // Tag and valid arrays
  input  cache_pkg::tag_t    ta_out,
  input  logic               valid_in,
  output logic               ta_read,
  output logic               ta_write,
  output logic               da_read,
  output logic               valid_read,
  // Captured store towards the merger
  store_if.ctrl              st
);
  import cache_pkg::*;

  store_state_t state;
  store_state_t next_state;

  // Store captured on accept
  word_t   addr_q;
  word_t   data_q;
  access_t type_q;

  // Tag field of the captured address
  tag_t    cap_tag;

  logic    accept;
  logic    hit;

  // New write taken only from idle
  assign accept = (state == st_idle) && core_req && core_write;

  assign cap_tag = addr_q[`ADDR_BITS-1 -: `TAG_BITS];

  // Arrays answer one cycle after the read, so compare in check_hit
  assign hit = valid_in && (ta_out == cap_tag);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= st_idle;
    end
    else
    begin
      state <= next_state;
    end
  end

  // Hold the store once the core is stalled
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q <= core_addr;
      data_q <= core_in;
      type_q <= core_type;
    end
  end

  always_comb
  begin
    next_state = state;
    case (state)
      st_idle:
      begin
        // Memory may take the write in the accept cycle itself
        if (accept)
        begin
          next_state = d_wait ? st_write_mem : st_read_array;
        end
      end
      st_write_mem:
      begin
        // Wait for memory
        if (!d_wait)
        begin
          next_state = st_read_array;
        end
      end
      st_read_array:
      begin
        next_state = st_check_hit;
      end
      st_check_hit:
      begin
        // Miss leaves the line alone, no allocation
        next_state = hit ? st_write_line : st_idle;
      end
      st_write_line:
      begin
        next_state = st_idle;
      end
      default:
      begin
        next_state = st_idle;
      end
    endcase
  end

  // Core stalled from the accept cycle until back in idle
  assign core_wait = accept || (state != st_idle);

  // Memory request held while memory waits
  assign d_req   = accept || (state == st_write_mem);
  assign d_write = accept || (state == st_write_mem);

  // Straight from the core in the accept cycle, captured copy after
  assign d_addr = (state == st_idle) ? core_addr : addr_q;
  assign d_in   = (state == st_idle) ? core_in   : data_q;
  assign d_type = (state == st_idle) ? core_type : type_q;

  // Single read cycle for tag, valid and data
  assign ta_read    = (state == st_read_array);
  assign da_read    = (state == st_read_array);
  assign valid_read = (state == st_read_array);

  // Tag rewritten with the line on a hit
  assign ta_write = (state == st_write_line);

  // Fields for the merger and the array index
  assign st.index    = addr_q[`OFFSET_BITS +: `INDEX_BITS];
  assign st.tag      = cap_tag;
  assign st.offset   = addr_q[`OFFSET_BITS-1:0];
  assign st.dtype    = type_q;
  assign st.wdata    = data_q;
  assign st.merge_en = (state == st_write_line);

endmodule

// ==== rtl/line_merge.sv ====
`timescale 1ns/10ps

module line_merge (
  // Captured store from the controller
  store_if.merge           st,
  // Placed write data for the data array
  output cache_pkg::line_t      da_in,
  // Byte-write mask, active low
  output cache_pkg::byte_mask_t da_write
);
  import cache_pkg::*;

  // Byte enables before shifting into place
  logic [3:0] lane_en;

  // Data bits that belong to the access size
  word_t      keep;

  // First byte lane touched by the store
  offset_t    lane;

  // Size decode, little-endian lanes
  always_comb
  begin
    lane_en = 4'b0000;
    keep    = '0;
    lane    = st.offset;
    case (st.dtype)
      acc_word:
      begin
        // Word slot from offset bits 3..2
        lane_en = 4'b1111;
        keep    = 32'hffff_ffff;
        lane    = {st.offset[3:2], 2'b00};
      end
      acc_hword,
      acc_hword_u:
      begin
        // Halfword at offset bit 1 times two inside the slot
        lane_en = 4'b0011;
        keep    = 32'h0000_ffff;
        lane    = {st.offset[3:1], 1'b0};
      end
      acc_byte,
      acc_byte_u:
      begin
        // Any byte lane
        lane_en = 4'b0001;
        keep    = 32'h0000_00ff;
        lane    = st.offset;
      end
      default:
      begin
        // Unknown type writes nothing
        lane_en = 4'b0000;
        keep    = '0;
        lane    = '0;
      end
    endcase
  end

  // Only the stored bytes are cleared in the mask
  assign da_write = st.merge_en ? ~(byte_mask_t'(lane_en) << lane) : '1;

  // Data moved to the same lanes, other bytes zero
  assign da_in = st.merge_en ? (line_t'(st.wdata & keep) << {lane, 3'b000}) : '0;

endmodule

// ==== rtl/cache_write.sv ====
`timescale 1ns/10ps

module cache_write (
  input  logic                  clk,
  input  logic                  rst,
  // Core side
  input  logic                  core_req,
  input  logic                  core_write,
  input  cache_pkg::word_t      core_addr,
  input  cache_pkg::word_t      core_in,
  input  cache_pkg::access_t    core_type,
  output logic                  core_wait,
  // Memory side, write-through
  output logic                  d_req,
  output logic                  d_write,
  output cache_pkg::word_t      d_addr,
  output cache_pkg::word_t      d_in,
  output cache_pkg::access_t    d_type,
  input  logic                  d_wait,
  // Tag and valid arrays
  output cache_pkg::index_t     index,
  output cache_pkg::tag_t       ta_in,
  output logic                  ta_read,
  output logic                  ta_write,
  output logic                  valid_read,
  input  cache_pkg::tag_t       ta_out,
  input  logic                  valid_in,
  // Data array, da_write active low per byte
  output cache_pkg::line_t      da_in,
  output cache_pkg::byte_mask_t da_write,
  output logic                  da_read
);

  // Captured store between controller and merger
  store_if st_bus ();

  store_ctrl u_store_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_in    (core_in),
    .core_type  (core_type),
    .core_wait  (core_wait),
    .d_req      (d_req),
    .d_write    (d_write),
    .d_addr     (d_addr),
    .d_in       (d_in),
    .d_type     (d_type),
    .d_wait     (d_wait),
    .ta_out     (ta_out),
    .valid_in   (valid_in),
    .ta_read    (ta_read),
    .ta_write   (ta_write),
    .da_read    (da_read),
    .valid_read (valid_read),
    .st         (st_bus.ctrl)
  );

  line_merge u_line_merge (
    .st       (st_bus.merge),
    .da_in    (da_in),
    .da_write (da_write)
  );

  // Array index and tag come from the captured address
  assign index = st_bus.index;
  assign ta_in = st_bus.tag;

endmodule

// ==== verif/cache_write_tb.sv ====
`timescale 1ns/10ps
`include "cache_consts.svh"

module cache_write_tb;
  import cache_pkg::*;

  // Stores per test group
  localparam integer N_WORD = 4;
  localparam integer N_BYTE = 32;
  localparam integer N_HWORD = 16;
  localparam integer N_MISS = 4;
  localparam integer N_RAND = 40;
  localparam integer NUM_STORES = N_WORD + N_BYTE + N_HWORD + N_MISS + N_RAND;
  localparam integer TIMEOUT_CYCLES = 40 * NUM_STORES;

  logic       clk;
  logic       rst;
  logic       core_req;
  logic       core_write;
  word_t      core_addr;
  word_t      core_in;
  access_t    core_type;
  logic       core_wait;
  logic       d_req;
  logic       d_write;
  word_t      d_addr;
  word_t      d_in;
  access_t    d_type;
  logic       d_wait;
  index_t     index;
  tag_t       ta_in;
  logic       ta_read;
  logic       ta_write;
  logic       valid_read;
  tag_t       ta_out;
  logic       valid_in;
  line_t      da_in;
  byte_mask_t da_write;
  logic       da_read;

  integer seed = 32'h4041bfe8;
  integer errors = 0;
  integer checks = 0;
  integer store_count = 0;
  integer done_count = 0;

  // Tag and valid contents, loaded before reset
  tag_t tag_mem [0:63];
  logic valid_mem [0:63];

  // Stores issued but not yet accepted by memory
  string       name_q [$];
  word_t       addr_q [$];
  word_t       data_q [$];
  logic [2:0]  type_q [$];
  logic        hit_q [$];

  // Store currently tracked by the checker
  string      cur_name;
  word_t      cur_addr;
  word_t      cur_data;
  logic [2:0] cur_type;
  logic       cur_hit;
  logic       in_flight = 1'b0;
  logic       req_seen = 1'b0;
  integer     acc_cycle = 0;
  integer     mon_cycle = 0;
  integer     wait_left;

  cache_write DUT (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_in    (core_in),
    .core_type  (core_type),
    .core_wait  (core_wait),
    .d_req      (d_req),
    .d_write    (d_write),
    .d_addr     (d_addr),
    .d_in       (d_in),
    .d_type     (d_type),
    .d_wait     (d_wait),
    .index      (index),
    .ta_in      (ta_in),
    .ta_read    (ta_read),
    .ta_write   (ta_write),
    .valid_read (valid_read),
    .ta_out     (ta_out),
    .valid_in   (valid_in),
    .da_in      (da_in),
    .da_write   (da_write),
    .da_read    (da_read)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Expected {mask, line} built byte by byte, little-endian
  function automatic logic [143:0] merge_ref(input logic [3:0] offset, input logic [2:0] dtype,
                                             input logic [31:0] data);
    logic [15:0]  mask;
    logic [127:0] line;
    integer       size;
    integer       base;
    integer       i;
    mask = '1;
    line = '0;
    case (dtype)
      `CACHE_WORD: size = 4;
      `CACHE_HWORD, `CACHE_HWORD_U: size = 2;
      `CACHE_BYTE, `CACHE_BYTE_U: size = 1;
      default: size = 0;
    endcase
    // Naturally aligned start byte
    base = (size == 0) ? 0 : (int'(offset) / size) * size;
    for (i = 0; i < 16; i = i + 1)
    begin
      if (i >= base && i < base + size)
      begin
        mask[i] = 1'b0;
        line[i*8 +: 8] = data[(i-base)*8 +: 8];
      end
    end
    return {mask, line};
  endfunction

  task automatic check_val(input string name, input logic [143:0] expected,
                           input logic [143:0] actual);
    checks = checks + 1;
    if (actual !== expected)
    begin
      errors = errors + 1;
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Memory stalls each request for 0 to 3 cycles
  initial
  begin
    d_wait = 1'b0;
    wait_left = {$random(seed)} % 4;
    forever
    begin
      @(posedge clk);
      if (!rst && d_req)
        wait_left = d_wait ? wait_left - 1 : {$random(seed)} % 4;
      @(negedge clk);
      d_wait = (wait_left > 0);
    end
  end

  // Tag and valid arrays answer in the cycle after the read
  // Output held until the next read
  initial
  begin : tag_array
    logic   rd;
    index_t rd_idx;
    ta_out = '0;
    valid_in = 1'b0;
    forever
    begin
      @(posedge clk);
      rd = ta_read && valid_read;
      rd_idx = index;
      @(negedge clk);
      if (rd)
      begin
        ta_out = tag_mem[rd_idx];
        valid_in = valid_mem[rd_idx];
      end
    end
  end

  // Cycle-exact compare against the expected store
  always @(posedge clk)
  begin : compare_outputs
    integer       k;
    integer       n;
    logic [143:0] exp_merge;
    mon_cycle = mon_cycle + 1;
    if (!rst && in_flight)
    begin
      // k counts cycles after memory accepted the write
      k = mon_cycle - acc_cycle;
      n = cur_hit ? 3 : 2;
      if (k > n)
      begin
        // Back in idle, the next store may start in this cycle
        in_flight = 1'b0;
        done_count = done_count + 1;
      end
      else
      begin
        exp_merge = merge_ref(cur_addr[3:0], cur_type, cur_data);
        check_val({cur_name, " d_req"}, 144'(1'b0), 144'(d_req));
        check_val({cur_name, " d_write"}, 144'(1'b0), 144'(d_write));
        check_val({cur_name, " ta_read"}, 144'(k == 1), 144'(ta_read));
        check_val({cur_name, " da_read"}, 144'(k == 1), 144'(da_read));
        check_val({cur_name, " valid_read"}, 144'(k == 1), 144'(valid_read));
        check_val({cur_name, " ta_write"}, 144'(cur_hit && k == 3), 144'(ta_write));
        check_val({cur_name, " core_wait"}, 144'(1'b1), 144'(core_wait));
        if (cur_hit && k == 3)
        begin
          check_val({cur_name, " da_write"}, 144'(exp_merge[143:128]), 144'(da_write));
          check_val({cur_name, " da_in"}, 144'(exp_merge[127:0]), 144'(da_in));
          check_val({cur_name, " index"}, 144'(cur_addr[9:4]), 144'(index));
          check_val({cur_name, " ta_in"}, 144'(cur_addr[31:10]), 144'(ta_in));
        end
        else
        begin
          check_val({cur_name, " da_write"}, 144'(16'hffff), 144'(da_write));
          check_val({cur_name, " da_in"}, 144'(0), 144'(da_in));
        end
      end
    end
    if (!rst && !in_flight && d_req)
    begin
      if (addr_q.size() == 0)
      begin
        errors = errors + 1;
        $display("Memory request seen while no store was issued");
      end
      else
      begin
        cur_name = name_q[0];
        cur_addr = addr_q[0];
        cur_data = data_q[0];
        cur_type = type_q[0];
        cur_hit = hit_q[0];
        // Write-through copy must match the core request
        check_val({cur_name, " d_addr"}, 144'(cur_addr), 144'(d_addr));
        check_val({cur_name, " d_in"}, 144'(cur_data), 144'(d_in));
        check_val({cur_name, " d_type"}, 144'(cur_type), 144'(d_type));
        check_val({cur_name, " d_write"}, 144'(1'b1), 144'(d_write));
        check_val({cur_name, " core_wait"}, 144'(1'b1), 144'(core_wait));
        check_val({cur_name, " ta_read"}, 144'(1'b0), 144'(ta_read));
        check_val({cur_name, " ta_write"}, 144'(1'b0), 144'(ta_write));
        check_val({cur_name, " da_write"}, 144'(16'hffff), 144'(da_write));
        req_seen = d_wait;
        if (!d_wait)
        begin
          void'(name_q.pop_front());
          void'(addr_q.pop_front());
          void'(data_q.pop_front());
          void'(type_q.pop_front());
          void'(hit_q.pop_front());
          acc_cycle = mon_cycle;
          in_flight = 1'b1;
        end
      end
    end
    else if (!rst && !in_flight)
    begin
      if (req_seen)
      begin
        errors = errors + 1;
        $display("Memory request dropped before the write was accepted");
      end
      req_seen = 1'b0;
      // Idle between stores
      check_val("idle core_wait", 144'(1'b0), 144'(core_wait));
      check_val("idle ta_read", 144'(1'b0), 144'(ta_read));
      check_val("idle ta_write", 144'(1'b0), 144'(ta_write));
      check_val("idle da_write", 144'(16'hffff), 144'(da_write));
    end
  end

  // Run limit from the number of stores
  initial
  begin : run_limit
    integer cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout: %0d of %0d stores done after %0d cycles", done_count, NUM_STORES,
             TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // One store from the core, then wait for core_wait to clear
  // Called on a falling edge
  task automatic run_store(input string name, input tag_t tag, input index_t idx,
                           input offset_t off, input logic [2:0] typ, input word_t data);
    word_t addr;
    logic  hit;
    addr = {tag, idx, off};
    hit = valid_mem[idx] && (tag_mem[idx] == tag);
    name_q.push_back(name);
    addr_q.push_back(addr);
    data_q.push_back(data);
    type_q.push_back(typ);
    hit_q.push_back(hit);
    store_count = store_count + 1;
    core_req = 1'b1;
    core_write = 1'b1;
    core_addr = addr;
    core_in = data;
    core_type = access_t'(typ);
    @(negedge clk);
    // Scramble inputs so only the captured copy can be used
    core_req = 1'b0;
    core_write = 1'b0;
    core_addr = $random(seed);
    core_in = $random(seed);
    core_type = (typ == `CACHE_WORD) ? acc_byte : acc_word;
    // Next store follows as soon as the core is released
    while (core_wait)
      @(negedge clk);
  endtask

  initial
  begin : stimulus
    integer     i;
    integer     o;
    word_t      r;
    index_t     idx;
    offset_t    off;
    logic [2:0] typ;
    tag_t       tag;
    rst = 1'b1;
    core_req = 1'b0;
    core_write = 1'b0;
    core_addr = '0;
    core_in = '0;
    core_type = acc_word;
    // Tag depends on every index bit, a few lines left invalid
    for (i = 0; i < 64; i = i + 1)
    begin
      idx = i[5:0];
      tag_mem[i] = {idx, ~idx, idx, idx[3:0]};
      valid_mem[i] = !(idx[5:3] == 3'b111 && idx[0]);
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_val("reset core_wait", 144'(1'b0), 144'(core_wait));
    check_val("reset d_req", 144'(1'b0), 144'(d_req));
    check_val("reset d_write", 144'(1'b0), 144'(d_write));
    check_val("reset ta_read", 144'(1'b0), 144'(ta_read));
    check_val("reset ta_write", 144'(1'b0), 144'(ta_write));
    check_val("reset da_read", 144'(1'b0), 144'(da_read));
    check_val("reset valid_read", 144'(1'b0), 144'(valid_read));
    check_val("reset da_write", 144'(16'hffff), 144'(da_write));
    check_val("reset da_in", 144'(0), 144'(da_in));
    // Word hits, one per slot
    for (i = 0; i < N_WORD; i = i + 1)
    begin
      idx = 6'd8 + 6'(i);
      run_store($sformatf("word slot %0d", i), tag_mem[idx], idx, {i[1:0], 2'b00}, `CACHE_WORD,
                $random(seed));
    end
    // Byte hits at all 16 lanes, signed then unsigned
    for (o = 0; o < N_BYTE; o = o + 1)
    begin
      idx = {2'b01, o[3:0]};
      typ = o[4] ? `CACHE_BYTE_U : `CACHE_BYTE;
      run_store($sformatf("byte %0d", o), tag_mem[idx], idx, o[3:0], typ, $random(seed));
    end
    // Halfword hits at all even offsets
    for (o = 0; o < N_HWORD; o = o + 1)
    begin
      idx = {3'b100, o[2:0]};
      typ = o[3] ? `CACHE_HWORD_U : `CACHE_HWORD;
      run_store($sformatf("hword %0d", o), tag_mem[idx], idx, {o[2:0], 1'b0}, typ, $random(seed));
    end
    // Misses by tag and by valid bit
    run_store("miss tag word", tag_mem[12] ^ 22'h3ff, 6'd12, 4'd4, `CACHE_WORD, $random(seed));
    run_store("miss tag byte", tag_mem[12] ^ 22'h001, 6'd12, 4'd9, `CACHE_BYTE, $random(seed));
    run_store("miss valid word", tag_mem[59], 6'd59, 4'd8, `CACHE_WORD, $random(seed));
    run_store("miss valid hword", tag_mem[59], 6'd59, 4'd2, `CACHE_HWORD_U, $random(seed));
    // Random mix, mostly hits
    for (i = 0; i < N_RAND; i = i + 1)
    begin
      r = $random(seed);
      idx = r[5:0];
      off = r[9:6];
      case (r[12:10] % 3'd5)
        3'd0: typ = `CACHE_BYTE;
        3'd1: typ = `CACHE_HWORD;
        3'd2: typ = `CACHE_WORD;
        3'd3: typ = `CACHE_BYTE_U;
        default: typ = `CACHE_HWORD_U;
      endcase
      tag = (r[14:13] != 2'b00) ? tag_mem[idx] : (tag_mem[idx] ^ 22'h1);
      run_store($sformatf("random %0d", i), tag, idx, off, typ, $random(seed));
    end
    // Checker retires the last store on the next rising edge
    @(negedge clk);
    $display("Stores: %0d, checks: %0d, errors: %0d", done_count, checks, errors);
    if (errors == 0 && done_count == NUM_STORES)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
rtl/cache_pkg.sv
rtl/store_if.sv
rtl/store_ctrl.sv
rtl/line_merge.sv
rtl/cache_write.sv
verif/cache_write_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TB_TOP     := cache_write_tb
RTL_TOP    := cache_write
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
